/* hw/axil_write_fsm.sv */
`timescale 1ns/1ps
`include "chess_ctrl_params.svh"

module axil_write_fsm
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic [`AXI_ADDR_WIDTH-1:0]        awaddr,
   input  logic                              awvalid,
   output logic                              awready,
   input  logic [`AXI_DATA_WIDTH-1:0]        wdata,
   input  logic                              wvalid,
   output logic                              wready,
   output logic                              bvalid,
   output logic [1:0]                        bresp,
   input  logic                              bready,
   output logic                              wr_strobe,
   output chess_ctrl_pkg::reg_index_t        wr_index,
   output logic [`AXI_DATA_WIDTH-1:0]        wr_data
);

   chess_ctrl_pkg::axil_wr_state_t state;
   chess_ctrl_pkg::axil_wr_state_t next_state;
   logic [`AXI_ADDR_WIDTH-1:2]               addr_q;
   logic [`AXI_DATA_WIDTH-1:0]               data_q;
   logic                                     aw_fire;
   logic                                     w_fire;

   assign awready = (state == chess_ctrl_pkg::WR_IDLE) || (state == chess_ctrl_pkg::WR_HAVE_DATA);
   assign wready  = (state == chess_ctrl_pkg::WR_IDLE) || (state == chess_ctrl_pkg::WR_HAVE_ADDR);
   assign bvalid  = (state == chess_ctrl_pkg::WR_RESP);
   assign bresp   = `AXI_RESP_OKAY;
   assign aw_fire = awvalid && awready;
   assign w_fire  = wvalid && wready;

   assign wr_index = chess_ctrl_pkg::reg_index_t'(addr_q);
   assign wr_data  = data_q;

   always_comb
   begin
      next_state = state;
      case (state)
         chess_ctrl_pkg::WR_IDLE:
         begin
            if (aw_fire && w_fire)
               next_state = chess_ctrl_pkg::WR_RESP;
            else if (aw_fire)
               next_state = chess_ctrl_pkg::WR_HAVE_ADDR;
            else if (w_fire)
               next_state = chess_ctrl_pkg::WR_HAVE_DATA;
         end
         chess_ctrl_pkg::WR_HAVE_ADDR: if (w_fire) next_state = chess_ctrl_pkg::WR_RESP;
         chess_ctrl_pkg::WR_HAVE_DATA: if (aw_fire) next_state = chess_ctrl_pkg::WR_RESP;
         chess_ctrl_pkg::WR_RESP: if (bready) next_state = chess_ctrl_pkg::WR_IDLE;
         default: next_state = chess_ctrl_pkg::WR_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= chess_ctrl_pkg::WR_IDLE;
         wr_strobe <= 1'b0;
      end
      else
      begin
         state     <= next_state;
         wr_strobe <= (next_state == chess_ctrl_pkg::WR_RESP) &&
                      (state != chess_ctrl_pkg::WR_RESP);  // First cycle of WR_RESP only
      end
   end

   always_ff @(posedge clk)
   begin
      if (aw_fire)
         addr_q <= awaddr[`AXI_ADDR_WIDTH-1:2];
      if (w_fire)
         data_q <= wdata;
   end

   // Response held under back-pressure
   assert property (@(posedge clk) disable iff (reset)
      (state == chess_ctrl_pkg::WR_RESP) && !bready |=> bvalid);

   assert property (@(posedge clk) disable iff (reset) wr_strobe |=> !wr_strobe);

endmodule

/* hw/chess_ctrl.sv */
`timescale 1ns/1ps
`include "chess_ctrl_params.svh"

module chess_ctrl
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic [`AXI_ADDR_WIDTH-1:0]          awaddr,
   input  logic                                awvalid,
   output logic                                awready,
   input  logic [`AXI_DATA_WIDTH-1:0]          wdata,
   input  logic                                wvalid,
   output logic                                wready,
   output logic                                bvalid,
   output logic [1:0]                          bresp,
   input  logic                                bready,
   input  logic [`AXI_ADDR_WIDTH-1:0]          araddr,
   input  logic                                arvalid,
   output logic                                arready,
   output logic                                rvalid,
   output logic [`AXI_DATA_WIDTH-1:0]          rdata,
   output logic [1:0]                          rresp,
   input  logic                                rready,
   output logic                                new_board_valid,
   output logic                                clear_moves,
   output logic                                soft_reset,
   output logic                                capture_only,
   output logic [`MAX_POSITIONS_LOG2-1:0]      move_index,
   output logic [`POS_FLAGS_WIDTH-1:0]         pos_flags,
   output logic [`HALF_MOVE_WIDTH-1:0]         half_move,
   output logic [`BOARD_WIDTH-1:0]             new_board,
   input  logic                                mg_idle,
   input  logic                                mg_moves_ready,
   input  logic                                mg_move_ready,
   input  logic [`MAX_POSITIONS_LOG2-1:0]      mg_move_count,
   input  logic signed [`EVAL_WIDTH-1:0]       mg_move_eval
);

   logic                                       wr_strobe;
   chess_ctrl_pkg::reg_index_t                 wr_index;
   logic [`AXI_DATA_WIDTH-1:0]                 wr_data;

   axil_write_fsm write_fsm_i
   (
      .clk, .reset, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
      .bvalid, .bresp, .bready, .wr_strobe, .wr_index, .wr_data
   );

   ctrl_reg_file reg_file_i
   (
      .clk, .reset, .wr_strobe, .wr_index, .wr_data,
      .new_board_valid, .clear_moves, .soft_reset, .capture_only,
      .move_index, .pos_flags, .half_move, .new_board
   );

   ctrl_read_port read_port_i
   (
      .clk, .reset, .araddr, .arvalid, .arready, .rvalid, .rdata, .rresp, .rready,
      .new_board_valid, .clear_moves, .soft_reset, .capture_only,
      .move_index, .pos_flags, .half_move, .new_board,
      .mg_idle, .mg_moves_ready, .mg_move_ready, .mg_move_count, .mg_move_eval
   );

endmodule

/* hw/chess_ctrl_pkg.sv */
`include "chess_ctrl_params.svh"

package chess_ctrl_pkg;

   typedef enum logic [1:0]
   {
      WR_IDLE,
      WR_HAVE_ADDR,
      WR_HAVE_DATA,
      WR_RESP
   } axil_wr_state_t;

   typedef enum logic [`REG_INDEX_WIDTH-1:0]
   {
      REG_CONTROL         = 0,
      REG_MOVE_INDEX      = 1,
      REG_POS_FLAGS       = 2,
      REG_HALF_MOVE       = 3,
      REG_CAPTURE_ONLY    = 4,
      REG_BOARD_0         = 8,  // Rank words run 8 to 15
      REG_BOARD_7         = 15,
      REG_STAT_EVAL       = 134,
      REG_STAT_MOVE_COUNT = 135
   } reg_index_t;

endpackage

/* hw/ctrl_read_port.sv */
`timescale 1ns/1ps
`include "chess_ctrl_params.svh"

module ctrl_read_port
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic [`AXI_ADDR_WIDTH-1:0]          araddr,
   input  logic                                arvalid,
   output logic                                arready,
   output logic                                rvalid,
   output logic [`AXI_DATA_WIDTH-1:0]          rdata,
   output logic [1:0]                          rresp,
   input  logic                                rready,
   input  logic                                new_board_valid,
   input  logic                                clear_moves,
   input  logic                                soft_reset,
   input  logic                                capture_only,
   input  logic [`MAX_POSITIONS_LOG2-1:0]      move_index,
   input  logic [`POS_FLAGS_WIDTH-1:0]         pos_flags,
   input  logic [`HALF_MOVE_WIDTH-1:0]         half_move,
   input  logic [`BOARD_WIDTH-1:0]             new_board,
   input  logic                                mg_idle,
   input  logic                                mg_moves_ready,
   input  logic                                mg_move_ready,
   input  logic [`MAX_POSITIONS_LOG2-1:0]      mg_move_count,
   input  logic signed [`EVAL_WIDTH-1:0]       mg_move_eval
);

   chess_ctrl_pkg::reg_index_t                 rd_index;
   logic [`AXI_DATA_WIDTH-1:0]                 rd_word;

   assign rd_index = chess_ctrl_pkg::reg_index_t'(araddr[`AXI_ADDR_WIDTH-1:2]);
   assign arready  = !rvalid;  // One answer outstanding at most
   assign rresp    = `AXI_RESP_OKAY;

   always_comb
   begin
      rd_word = '0;
      case (rd_index)
         chess_ctrl_pkg::REG_CONTROL:
         begin
            rd_word[0]  = new_board_valid;
            rd_word[1]  = clear_moves;
            rd_word[2]  = mg_moves_ready;
            rd_word[3]  = mg_move_ready;
            rd_word[7]  = mg_idle;
            rd_word[31] = soft_reset;
         end
         chess_ctrl_pkg::REG_MOVE_INDEX: rd_word[`MAX_POSITIONS_LOG2-1:0] = move_index;
         chess_ctrl_pkg::REG_POS_FLAGS: rd_word[`POS_FLAGS_WIDTH-1:0] = pos_flags;
         chess_ctrl_pkg::REG_HALF_MOVE: rd_word[`HALF_MOVE_WIDTH-1:0] = half_move;
         chess_ctrl_pkg::REG_CAPTURE_ONLY: rd_word[0] = capture_only;
         chess_ctrl_pkg::REG_STAT_EVAL:
            rd_word = {{(`AXI_DATA_WIDTH - `EVAL_WIDTH){mg_move_eval[`EVAL_WIDTH-1]}}, mg_move_eval};
         chess_ctrl_pkg::REG_STAT_MOVE_COUNT: rd_word[`MAX_POSITIONS_LOG2-1:0] = mg_move_count;
         default: rd_word = '0;
      endcase
      for (int k = 0; k < `RANK_WORDS; k++)
      begin
         if (int'(rd_index) == int'(chess_ctrl_pkg::REG_BOARD_0) + k)
            rd_word = new_board[k*`SIDE_WIDTH +: `SIDE_WIDTH];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rvalid <= 1'b0;
         rdata  <= '0;
      end
      else if (arvalid && arready)
      begin
         rvalid <= 1'b1;
         rdata  <= rd_word;
      end
      else if (rready)
         rvalid <= 1'b0;
   end

   // Answer held until the host takes it
   assert property (@(posedge clk) disable iff (reset)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* hw/ctrl_reg_file.sv */
`timescale 1ns/1ps
`include "chess_ctrl_params.svh"

module ctrl_reg_file
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              wr_strobe,
   input  chess_ctrl_pkg::reg_index_t        wr_index,
   input  logic [`AXI_DATA_WIDTH-1:0]        wr_data,
   output logic                              new_board_valid,
   output logic                              clear_moves,
   output logic                              soft_reset,
   output logic                              capture_only,
   output logic [`MAX_POSITIONS_LOG2-1:0]    move_index,
   output logic [`POS_FLAGS_WIDTH-1:0]       pos_flags,
   output logic [`HALF_MOVE_WIDTH-1:0]       half_move,
   output logic [`BOARD_WIDTH-1:0]           new_board
);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         new_board_valid <= 1'b0;
         clear_moves     <= 1'b0;
         soft_reset      <= 1'b0;
         capture_only    <= 1'b0;
         move_index      <= '0;
         pos_flags       <= '0;
         half_move       <= '0;
         new_board       <= '0;
      end
      else if (wr_strobe)
      begin
         case (wr_index)
            chess_ctrl_pkg::REG_CONTROL:
            begin
               new_board_valid <= wr_data[0];
               clear_moves     <= wr_data[1];
               soft_reset      <= wr_data[31];
            end
            chess_ctrl_pkg::REG_MOVE_INDEX: move_index <= wr_data[`MAX_POSITIONS_LOG2-1:0];
            chess_ctrl_pkg::REG_POS_FLAGS: pos_flags <= wr_data[`POS_FLAGS_WIDTH-1:0];
            chess_ctrl_pkg::REG_HALF_MOVE: half_move <= wr_data[`HALF_MOVE_WIDTH-1:0];
            chess_ctrl_pkg::REG_CAPTURE_ONLY: capture_only <= wr_data[0];
            default:
            begin
            end
         endcase

         // Rank words of the board to load
         for (int k = 0; k < `RANK_WORDS; k++)
         begin
            if (int'(wr_index) == int'(chess_ctrl_pkg::REG_BOARD_0) + k)
               new_board[k*`SIDE_WIDTH +: `SIDE_WIDTH] <= wr_data[`SIDE_WIDTH-1:0];
         end
      end
   end

   // Registers only move on the write strobe
   assert property (@(posedge clk) disable iff (reset)
      !wr_strobe |=> $stable({new_board_valid, clear_moves, soft_reset, capture_only,
                              move_index, pos_flags, half_move, new_board}));

endmodule

/* include/chess_ctrl_params.svh */
`ifndef CHESS_CTRL_PARAMS_SVH
`define CHESS_CTRL_PARAMS_SVH

// One rank word of the board
`define SIDE_WIDTH 32
`define RANK_WORDS 8
`define BOARD_WIDTH (`SIDE_WIDTH * `RANK_WORDS)

// Bus widths
`define AXI_ADDR_WIDTH 16
`define AXI_DATA_WIDTH 32

// Word index is the byte address without its two low bits
`define REG_INDEX_WIDTH (`AXI_ADDR_WIDTH - 2)

// Move generator fields
`define MAX_POSITIONS_LOG2 8
`define HALF_MOVE_WIDTH 8
`define EVAL_WIDTH 24

// White to move, castle mask, en-passant column
`define POS_FLAGS_WIDTH 9

`define AXI_RESP_OKAY 2'b00

`endif

/* run.sh */
#!/bin/sh
# Build and run the chess_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_chess_ctrl -f tb.f -o sim_chess_ctrl
./obj_dir/sim_chess_ctrl | tee sim.log

if grep -qx "Regression passed" sim.log; then
   exit 0
else
   exit 1
fi

/* tb.f */
+incdir+include
hw/chess_ctrl_pkg.sv
hw/axil_write_fsm.sv
hw/ctrl_reg_file.sv
hw/ctrl_read_port.sv
hw/chess_ctrl.sv
testbench/tb_chess_ctrl.sv

/* testbench/ctrl_cases.txt */
# op addr data expected, all hex. W writes then reads back, R reads, S sets status inputs
# S addr: 0 flags (bit0 idle, bit1 moves_ready, bit2 move_ready), 1 count, 2 eval; P addr: word index
R 0000 00000000 00000000
R 0004 00000000 00000000
R 0008 00000000 00000000
R 002C 00000000 00000000
P 0000 00000000 00000000
W 0000 FFFFFFFF 80000003
W 0004 123456A5 000000A5
W 0008 0000FFFF 000001FF
W 000C 00000177 00000077
W 0010 00000003 00000001
# Board rank words 0 to 7
W 0020 01234567 01234567
W 0024 89ABCDEF 89ABCDEF
W 0028 FEDCBA98 FEDCBA98
W 002C 76543210 76543210
W 0030 A5A5A5A5 A5A5A5A5
W 0034 5A5A5A5A 5A5A5A5A
W 0038 0F0F0F0F 0F0F0F0F
W 003C F0F0F0F0 F0F0F0F0
# Status view
S 0000 00000007 00000000
R 0000 00000000 8000008F
S 0001 0000002A 00000000
R 021C 00000000 0000002A
S 0002 00FFFF85 00000000
R 0218 00000000 FFFFFF85
# Unmapped and read-only writes
W 0040 DEADBEEF 00000000
W 021C 000000FF 0000002A
P 0000 00000000 80000003
P 0002 00000000 000001FF
P 000F 00000000 F0F0F0F0
R 0004 00000000 000000A5
R 0100 00000000 00000000

/* testbench/tb_chess_ctrl.sv */
`timescale 1ns/1ps
`include "chess_ctrl_params.svh"

module tb_chess_ctrl;

   localparam int WAIT_LIMIT = 50;

   logic                                clk;
   logic                                reset;
   logic [`AXI_ADDR_WIDTH-1:0]          awaddr;
   logic                                awvalid;
   logic                                awready;
   logic [`AXI_DATA_WIDTH-1:0]          wdata;
   logic                                wvalid;
   logic                                wready;
   logic                                bvalid;
   logic [1:0]                          bresp;
   logic                                bready;
   logic [`AXI_ADDR_WIDTH-1:0]          araddr;
   logic                                arvalid;
   logic                                arready;
   logic                                rvalid;
   logic [`AXI_DATA_WIDTH-1:0]          rdata;
   logic [1:0]                          rresp;
   logic                                rready;
   logic                                new_board_valid;
   logic                                clear_moves;
   logic                                soft_reset;
   logic                                capture_only;
   logic [`MAX_POSITIONS_LOG2-1:0]      move_index;
   logic [`POS_FLAGS_WIDTH-1:0]         pos_flags;
   logic [`HALF_MOVE_WIDTH-1:0]         half_move;
   logic [`BOARD_WIDTH-1:0]             new_board;
   logic                                mg_idle;
   logic                                mg_moves_ready;
   logic                                mg_move_ready;
   logic [`MAX_POSITIONS_LOG2-1:0]      mg_move_count;
   logic signed [`EVAL_WIDTH-1:0]       mg_move_eval;

   int                                  seed;
   int                                  error_count = 0;
   int                                  strobe_count = 0;
   logic                                hung = 1'b0;

   chess_ctrl dut_i
   (
      .clk, .reset, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
      .bvalid, .bresp, .bready, .araddr, .arvalid, .arready, .rvalid, .rdata,
      .rresp, .rready, .new_board_valid, .clear_moves, .soft_reset, .capture_only,
      .move_index, .pos_flags, .half_move, .new_board,
      .mg_idle, .mg_moves_ready, .mg_move_ready, .mg_move_count, .mg_move_eval
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Register file write strobes seen so far
   always @(negedge clk)
   begin
      if (!reset && dut_i.write_fsm_i.wr_strobe)
         strobe_count <= strobe_count + 1;
   end

   function automatic int rand_delay(input int span);
      return $unsigned($random(seed)) % span;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual)
      begin
         error_count++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic report_hang(input string channel);
      $display("Timeout: the %s channel did not complete within %0d cycles", channel, WAIT_LIMIT);
      error_count++;
      hung = 1'b1;
   endtask

   // Output ports packed the way the register map lays them out
   function automatic logic [31:0] port_word(input int index);
      logic [31:0] word;
      word = '0;
      case (index)
         0:
         begin
            word[0]  = new_board_valid;
            word[1]  = clear_moves;
            word[31] = soft_reset;
         end
         1: word[`MAX_POSITIONS_LOG2-1:0] = move_index;
         2: word[`POS_FLAGS_WIDTH-1:0] = pos_flags;
         3: word[`HALF_MOVE_WIDTH-1:0] = half_move;
         4: word[0] = capture_only;
         default:
         begin
            if (index >= 8 && index < 8 + `RANK_WORDS)
               word = new_board[(index - 8)*`SIDE_WIDTH +: `SIDE_WIDTH];
         end
      endcase
      return word;
   endfunction

   task automatic axi_write(input logic [`AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                            input int aw_delay, input int w_delay, input int b_delay);
      int   cycles;
      logic aw_done;
      logic w_done;
      logic aw_beat;
      logic w_beat;
      cycles  = 0;
      aw_done = 1'b0;
      w_done  = 1'b0;
      @(posedge clk);
      awaddr <= addr;
      wdata  <= data;
      while (!(aw_done && w_done) && cycles < WAIT_LIMIT)
      begin
         awvalid <= !aw_done && (cycles >= aw_delay);
         wvalid  <= !w_done && (cycles >= w_delay);
         @(negedge clk);
         aw_beat = awvalid && awready;
         w_beat  = wvalid && wready;
         @(posedge clk);  // Beats transfer here
         aw_done = aw_done || aw_beat;
         w_done  = w_done || w_beat;
         cycles++;
      end
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      if (!(aw_done && w_done))
         report_hang(aw_done ? "write data" : "write address");
      else
      begin
         cycles = 0;
         @(negedge clk);
         while (!bvalid && cycles < WAIT_LIMIT)
         begin
            @(negedge clk);
            cycles++;
         end
         if (!bvalid)
            report_hang("write response");
         else
         begin
            check("bresp", 32'(`AXI_RESP_OKAY), 32'(bresp));
            repeat (b_delay)
            begin
               @(negedge clk);
               check("bvalid", 32'd1, 32'(bvalid));  // Held under back-pressure
               check("awready", 32'd0, 32'(awready));
               check("wready", 32'd0, 32'(wready));
            end
            @(posedge clk);
            bready <= 1'b1;
            @(posedge clk);
            bready <= 1'b0;
         end
      end
   endtask

   task automatic axi_read(input logic [`AXI_ADDR_WIDTH-1:0] addr, input int r_delay,
                           output logic [31:0] value);
      int          cycles;
      logic [31:0] held;
      cycles = 0;
      value  = '0;
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      @(negedge clk);
      while (!arready && cycles < WAIT_LIMIT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!arready)
         report_hang("read address");
      else
      begin
         @(posedge clk);
         arvalid <= 1'b0;
         cycles = 0;
         @(negedge clk);
         while (!rvalid && cycles < WAIT_LIMIT)
         begin
            @(negedge clk);
            cycles++;
         end
         if (!rvalid)
            report_hang("read data");
         else
         begin
            held = rdata;
            check("rresp", 32'(`AXI_RESP_OKAY), 32'(rresp));
            repeat (r_delay)
            begin
               @(negedge clk);
               check("rvalid", 32'd1, 32'(rvalid));
               check("rdata", held, rdata);  // Must not move while rready is low
               check("arready", 32'd0, 32'(arready));
            end
            @(posedge clk);
            rready <= 1'b1;
            @(posedge clk);
            rready <= 1'b0;
            value = held;
         end
      end
   endtask

   task automatic run_case(input logic [7:0] op, input logic [`AXI_ADDR_WIDTH-1:0] addr,
                           input logic [31:0] data, input logic [31:0] expected);
      int          index;
      int          sel;
      int          strobes_before;
      int          aw_delay;
      int          w_delay;
      int          b_delay;
      int          r_delay;
      logic [31:0] got;
      index    = int'(addr[`AXI_ADDR_WIDTH-1:2]);
      sel      = int'(addr);
      aw_delay = rand_delay(4);
      w_delay  = rand_delay(4);
      b_delay  = rand_delay(6);
      r_delay  = rand_delay(4);
      case (op)
         "W":
         begin
            strobes_before = strobe_count;
            axi_write(addr, data, aw_delay, w_delay, b_delay);
            if (!hung)
            begin
               check("wr_strobe count", 32'(strobes_before + 1), 32'(strobe_count));
               axi_read(addr, r_delay, got);
               check($sformatf("rdata at %h", addr), expected, got);
               if (index <= 4 || (index >= 8 && index < 8 + `RANK_WORDS))
                  check($sformatf("port word %0d", index), expected, port_word(index));
            end
         end
         "R":
         begin
            axi_read(addr, r_delay, got);
            check($sformatf("rdata at %h", addr), expected, got);
         end
         "S":
         begin
            @(posedge clk);
            case (sel)
               0:
               begin
                  mg_idle        <= data[0];
                  mg_moves_ready <= data[1];
                  mg_move_ready  <= data[2];
               end
               1: mg_move_count <= data[`MAX_POSITIONS_LOG2-1:0];
               default: mg_move_eval <= data[`EVAL_WIDTH-1:0];
            endcase
         end
         "P":
         begin
            @(negedge clk);
            check($sformatf("port word %0d", sel), expected, port_word(sel));
         end
         default:
         begin
            error_count++;
            $display("Unknown operation '%c' in the case file", op);
         end
      endcase
   endtask

   initial
   begin
      int                         fd;
      int                         items;
      int                         errors_before;
      int                         test_num;
      int                         pass_count;
      int                         fail_count;
      logic [63:0]                op_text;
      logic [1023:0]              line_rest;
      logic [`AXI_ADDR_WIDTH-1:0] addr;
      logic [31:0]                data;
      logic [31:0]                expected;
      seed       = 32'h8769;
      test_num   = 0;
      pass_count = 0;
      fail_count = 0;
      reset          <= 1'b1;
      awaddr         <= '0;
      awvalid        <= 1'b0;
      wdata          <= '0;
      wvalid         <= 1'b0;
      bready         <= 1'b0;
      araddr         <= '0;
      arvalid        <= 1'b0;
      rready         <= 1'b0;
      mg_idle        <= 1'b0;
      mg_moves_ready <= 1'b0;
      mg_move_ready  <= 1'b0;
      mg_move_count  <= '0;
      mg_move_eval   <= '0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      fd = $fopen("testbench/ctrl_cases.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the case file testbench/ctrl_cases.txt");
         fail_count++;
      end
      else
      begin
         while (!$feof(fd) && !hung)
         begin
            items = $fscanf(fd, "%s", op_text);
            if (items == 1 && op_text[7:0] == "#")
               items = $fgets(line_rest, fd);  // Comment line
            else if (items == 1)
            begin
               items = $fscanf(fd, "%h %h %h", addr, data, expected);
               errors_before = error_count;
               test_num++;
               run_case(op_text[7:0], addr, data, expected);
               if (error_count == errors_before)
                  pass_count++;
               else
                  fail_count++;
               $display("Test %0d (%c %h %h): %s", test_num, op_text[7:0], addr, data,
                        (error_count == errors_before) ? "ok" : "mismatch");
            end
         end
         $fclose(fd);
      end

      $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
      if (fail_count == 0 && test_num > 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule
